//--- Makefile
SRCS := $(wildcard src/*.sv dv/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vdbg_tb: $(SRCS) dbg_top.f
	verilator --binary --timing --assert --top-module dbg_tb -f dbg_top.f

run: obj_dir/Vdbg_tb
	./obj_dir/Vdbg_tb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dbg_top.f
src/dbg_pkg.sv
src/dbg_cmd_fifo.sv
src/dbg_bus_master.sv
src/dbg_bus_unit.sv
src/dbg_cpu_unit.sv
src/dbg_top.sv
dv/dbg_checker.sv
dv/dbg_tb.sv

//--- dv/dbg_checker.sv
////////////////////
// Debug chain checker
// Decodes shifted commands, reference model of bus and CPU units
// Compares bus requests, scanned status words and stall outputs
////////////////////
`timescale 1ns/1ps
`default_nettype none

module dbg_checker #(
  parameter int FIFO_DEPTH = 4,
  parameter int NUM_CPUS   = 2
) (
  input  wire logic                  tck_i,
  input  wire logic                  tlr_i,
  input  wire logic                  tdi_i,
  input  wire logic                  shift_dr_i,
  input  wire logic                  capture_dr_i,
  input  wire logic                  update_dr_i,
  input  wire logic                  debug_select_i,
  input  wire logic                  tdo_i,
  input  wire logic                  bus_req_valid_i,
  input  wire dbg_pkg::dbg_bus_req_t bus_req_i,
  input  wire logic                  bus_req_ready_i,
  input  wire logic                  bus_rsp_valid_i,
  input  wire logic [NUM_CPUS-1:0]   cpu_bp_i,
  input  wire logic [NUM_CPUS-1:0]   cpu_stall_i,
  output int                         accepted_o,
  output int                         checks_o,
  output int                         errors_o
);

  localparam int LEN = dbg_pkg::DATAREG_LEN;

  // Chain decode and scan capture
  logic [LEN-1:0]      sreg;
  logic [LEN-1:0]      got;
  logic [LEN-1:0]      exp_word;
  int                  nshift;
  logic                armed;
  // Bus unit model
  logic [1:0]          id_m;
  int                  inflight;
  logic                err_m;
  logic                ovf_m;
  logic [31:0]         rdata_m;
  dbg_pkg::dbg_cmd_t   exp_q [$];
  dbg_pkg::dbg_cmd_t   cur;
  dbg_pkg::dbg_cmd_t   c;
  logic [31:0]         mem_m [logic [15:0]];
  // CPU unit model
  logic [NUM_CPUS-1:0] stall_m;
  logic [NUM_CPUS-1:0] bp_prev;
  logic [NUM_CPUS-1:0] bp_rise;
  logic                stall_done;

  // Untouched memory holds a pattern of its address
  function automatic logic [31:0] fill_word(input logic [15:0] addr);
    return {~addr, addr ^ 16'h3C5A};
  endfunction

  function automatic logic [31:0] mem_read(input logic [15:0] addr);
    if (mem_m.exists(addr)) begin
      return mem_m[addr];
    end
    return fill_word(addr);
  endfunction

  task automatic check_value(input string name, input logic [63:0] act, input logic [63:0] exp);
    checks_o++;
    if (act !== exp) begin
      errors_o++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, act, exp, $time);
    end
  endtask

  ////////////////////
  // Model update
  ////////////////////

  always @(posedge tck_i) begin
    if (tlr_i) begin
      sreg     = '0;
      got      = '0;
      exp_word = '0;
      nshift   = 0;
      armed    = 1'b0;
      id_m     = dbg_pkg::BUS_MODULE_ID;
      inflight = 0;
      err_m    = 1'b0;
      ovf_m    = 1'b0;
      rdata_m  = '0;
      stall_m  = '0;
      bp_prev  = '0;
      cur      = '0;
      exp_q.delete();
    end else begin
      bp_rise    = cpu_bp_i & ~bp_prev;
      stall_done = 1'b0;
      // Status word the selected unit should load
      if (capture_dr_i && debug_select_i) begin
        exp_word = '0;
        got      = '0;
        case (id_m)
          dbg_pkg::BUS_MODULE_ID: begin
            exp_word[dbg_pkg::STATUS_LEN-1:0] = {inflight != 0, ovf_m, err_m, rdata_m};
            err_m = 1'b0;
            ovf_m = 1'b0;
          end
          dbg_pkg::CPU_MODULE_ID: exp_word[2*NUM_CPUS-1:0] = {bp_prev, stall_m};
          default: exp_word = '0;
        endcase
        nshift = 0;
        armed  = 1'b1;
      end
      if (shift_dr_i && debug_select_i) begin
        if (nshift < LEN) begin
          got[nshift] = tdo_i;
        end
        nshift++;
        sreg = {tdi_i, sreg[LEN-1:1]};
      end
      if (update_dr_i && debug_select_i) begin
        if (armed) begin
          check_value("tdo_o scan", 64'(got), 64'(exp_word));
        end
        armed = 1'b0;
        if (sreg[LEN-1]) begin
          // Select honoured only with no bus work outstanding
          if (inflight == 0) begin
            id_m = sreg[LEN-2 -: 2];
          end
        end else begin
          c = sreg[LEN-2:0];
          if (id_m == dbg_pkg::BUS_MODULE_ID &&
              (c.op == dbg_pkg::DBG_WRITE || c.op == dbg_pkg::DBG_READ)) begin
            // FIFO plus the one held by the master
            if (inflight < FIFO_DEPTH + 1) begin
              exp_q.push_back(c);
              inflight++;
              accepted_o++;
            end else begin
              ovf_m = 1'b1;
            end
          end else if (id_m == dbg_pkg::CPU_MODULE_ID && c.op == dbg_pkg::DBG_STALL) begin
            stall_m    = c.data[NUM_CPUS-1:0] | bp_rise;
            stall_done = 1'b1;
          end
        end
      end
      // Bus request handshake, in command order
      if (bus_req_valid_i && bus_req_ready_i) begin
        if (exp_q.size() == 0) begin
          errors_o++;
          $display("bus request accepted with no command outstanding at %0t", $time);
        end else begin
          cur = exp_q.pop_front();
          check_value("bus_req_o.we", 64'(bus_req_i.we), 64'(cur.op == dbg_pkg::DBG_WRITE));
          check_value("bus_req_o.addr", 64'(bus_req_i.addr), 64'(cur.addr));
          check_value("bus_req_o.wdata", 64'(bus_req_i.wdata), 64'(cur.data));
        end
      end
      if (bus_rsp_valid_i) begin
        if (inflight > 0) begin
          inflight--;
        end
        // Address bit 15 means error, nothing written
        if (cur.addr[15]) begin
          err_m = 1'b1;
        end else if (cur.op == dbg_pkg::DBG_WRITE) begin
          mem_m[cur.addr] = cur.data;
        end
        if (cur.op == dbg_pkg::DBG_READ) begin
          rdata_m = mem_read(cur.addr);
        end
      end
      if (!stall_done) begin
        stall_m = stall_m | bp_rise;
      end
      bp_prev = cpu_bp_i;
    end
  end

  // Outputs settled mid-cycle
  always @(negedge tck_i) begin
    if (!tlr_i) begin
      check_value("cpu_stall_o", 64'(cpu_stall_i), 64'(stall_m));
      if (bus_req_valid_i && exp_q.size() == 0) begin
        errors_o++;
        $display("bus request raised with no command outstanding at %0t", $time);
      end
    end
  end

  initial begin
    accepted_o = 0;
    checks_o   = 0;
    errors_o   = 0;
  end

endmodule

`default_nettype wire

//--- dv/dbg_tb.sv
////////////////////
// Debug subsystem testbench
// Clock, reset, JTAG scan tasks, bus memory responder
// Directed and random tests, timeout
////////////////////
`timescale 1ns/1ps
`default_nettype none

module dbg_tb;

  localparam int FIFO_DEPTH  = 4;
  localparam int NUM_CPUS    = 2;
  localparam int NUM_RW      = 12;
  localparam int NUM_OPS     = 60;
  localparam int CYCLE_LIMIT = NUM_OPS * (2 * dbg_pkg::DATAREG_LEN + 16) + 200;

  logic                  tck;
  logic                  tlr;
  logic                  tdi;
  logic                  shift_dr;
  logic                  capture_dr;
  logic                  update_dr;
  logic                  debug_select;
  logic                  tdo;
  logic                  bus_req_valid;
  dbg_pkg::dbg_bus_req_t bus_req;
  logic                  bus_req_ready;
  logic                  bus_rsp_valid;
  dbg_pkg::dbg_bus_rsp_t bus_rsp;
  logic [NUM_CPUS-1:0]   cpu_bp;
  logic [NUM_CPUS-1:0]   cpu_stall;

  int                    accepted_cnt;
  int                    check_cnt;
  int                    error_cnt;
  int                    err_base;
  int                    test_num;
  int                    rsp_count;
  int                    cycle_count;
  int                    delay;
  logic                  bus_hold;
  logic [31:0]           stim_seed;
  logic [31:0]           rsp_seed;
  logic [15:0]           addrs [NUM_RW];
  logic [31:0]           mem [logic [15:0]];
  dbg_pkg::dbg_bus_req_t req;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] read_mem(input logic [15:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {~addr, addr ^ 16'h3C5A};
  endfunction

  // Clock and timeout
  initial tck = 1'b0;
  always #4 tck = ~tck;

  always @(posedge tck) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////
  // JTAG scan tasks
  ////////////////////

  // Capture, 51 shifts LSB first, then update
  task automatic scan_dr(input logic [dbg_pkg::DATAREG_LEN-1:0] word);
    @(posedge tck);
    capture_dr <= 1'b1;
    @(posedge tck);
    capture_dr <= 1'b0;
    shift_dr   <= 1'b1;
    tdi        <= word[0];
    for (int i = 1; i < dbg_pkg::DATAREG_LEN; i++) begin
      @(posedge tck);
      tdi <= word[i];
    end
    @(posedge tck);
    shift_dr  <= 1'b0;
    tdi       <= 1'b0;
    update_dr <= 1'b1;
    @(posedge tck);
    update_dr <= 1'b0;
  endtask

  task automatic select_module(input logic [1:0] id);
    scan_dr({1'b1, id, 48'd0});
  endtask

  task automatic send_cmd(input dbg_pkg::dbg_op_e op, input logic [15:0] addr,
                          input logic [31:0] data);
    scan_dr({1'b0, op, addr, data});
  endtask

  // Until every accepted command is answered and the pending count settles
  task automatic wait_idle();
    @(negedge tck);
    while (rsp_count != accepted_cnt || bus_req_valid) begin
      @(negedge tck);
    end
    repeat (2) @(posedge tck);
  endtask

  task automatic report_test(input string name);
    @(negedge tck);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, error_cnt - err_base);
    err_base = error_cnt;
  endtask

  ////////////////////
  // Bus memory responder
  ////////////////////

  always begin
    @(posedge tck);
    if (!tlr && bus_req_valid && !bus_hold) begin
      rsp_seed = xorshift32(rsp_seed);
      delay    = int'(rsp_seed % 32'd8);
      repeat (delay) @(posedge tck);
      bus_req_ready <= 1'b1;
      req = bus_req;
      @(posedge tck);
      bus_req_ready <= 1'b0;
      bus_rsp.err   <= req.addr[15];
      bus_rsp.rdata <= req.we ? 32'd0 : read_mem(req.addr);
      if (req.we && !req.addr[15]) begin
        mem[req.addr] = req.wdata;
      end
      bus_rsp_valid <= 1'b1;
      @(posedge tck);
      bus_rsp_valid <= 1'b0;
      rsp_count++;
    end
  end

  ////////////////////
  // DUT and checker
  ////////////////////

  dbg_top #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .NUM_CPUS  (NUM_CPUS)
  ) dbg_top_inst (
    .tck_i          (tck),
    .tlr_i          (tlr),
    .tdi_i          (tdi),
    .shift_dr_i     (shift_dr),
    .capture_dr_i   (capture_dr),
    .update_dr_i    (update_dr),
    .debug_select_i (debug_select),
    .tdo_o          (tdo),
    .bus_req_valid_o(bus_req_valid),
    .bus_req_o      (bus_req),
    .bus_req_ready_i(bus_req_ready),
    .bus_rsp_valid_i(bus_rsp_valid),
    .bus_rsp_i      (bus_rsp),
    .cpu_bp_i       (cpu_bp),
    .cpu_stall_o    (cpu_stall)
  );

  dbg_checker #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .NUM_CPUS  (NUM_CPUS)
  ) u_checker (
    .tck_i          (tck),
    .tlr_i          (tlr),
    .tdi_i          (tdi),
    .shift_dr_i     (shift_dr),
    .capture_dr_i   (capture_dr),
    .update_dr_i    (update_dr),
    .debug_select_i (debug_select),
    .tdo_i          (tdo),
    .bus_req_valid_i(bus_req_valid),
    .bus_req_i      (bus_req),
    .bus_req_ready_i(bus_req_ready),
    .bus_rsp_valid_i(bus_rsp_valid),
    .cpu_bp_i       (cpu_bp),
    .cpu_stall_i    (cpu_stall),
    .accepted_o     (accepted_cnt),
    .checks_o       (check_cnt),
    .errors_o       (error_cnt)
  );

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    tlr           = 1'b1;
    tdi           = 1'b0;
    shift_dr      = 1'b0;
    capture_dr    = 1'b0;
    update_dr     = 1'b0;
    debug_select  = 1'b0;
    bus_req_ready = 1'b0;
    bus_rsp_valid = 1'b0;
    bus_rsp       = '0;
    cpu_bp        = '0;
    bus_hold      = 1'b0;
    cycle_count   = 0;
    rsp_count     = 0;
    err_base      = 0;
    test_num      = 0;
    stim_seed     = 32'd99576;
    rsp_seed      = xorshift32(32'd99576 ^ 32'h5555AAAA);
    repeat (5) @(posedge tck);
    tlr          <= 1'b0;
    debug_select <= 1'b1;

    // Reset state scans out as zeros
    send_cmd(dbg_pkg::DBG_NOP, 16'd0, 32'd0);
    report_test("reset");

    // Random writes, then reads of the same addresses
    for (int i = 0; i < NUM_RW; i++) begin
      stim_seed = xorshift32(stim_seed);
      addrs[i]  = {stim_seed[31] & stim_seed[30], 11'd0, stim_seed[3:0]};
      stim_seed = xorshift32(stim_seed);
      send_cmd(dbg_pkg::DBG_WRITE, addrs[i], stim_seed);
      wait_idle();
    end
    for (int i = 0; i < NUM_RW; i++) begin
      send_cmd(dbg_pkg::DBG_READ, addrs[i], 32'd0);
      wait_idle();
    end
    send_cmd(dbg_pkg::DBG_NOP, 16'd0, 32'd0);
    report_test("write read");

    // Every id in turn with reserved ids scanning zeros
    // Held breakpoint and last read data keep the two unit words apart
    @(posedge tck);
    cpu_bp <= NUM_CPUS'(2);
    for (int id = 0; id < 4; id++) begin
      select_module(2'(id));
      send_cmd(dbg_pkg::DBG_NOP, 16'd0, 32'd0);
    end
    select_module(dbg_pkg::BUS_MODULE_ID);
    cpu_bp <= '0;
    report_test("module select");

    // Two commands past capacity with the bus stalled
    bus_hold <= 1'b1;
    for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
      stim_seed = xorshift32(stim_seed);
      send_cmd(dbg_pkg::DBG_WRITE, 16'h0040 + 16'(i), stim_seed);
    end
    send_cmd(dbg_pkg::DBG_NOP, 16'd0, 32'd0);
    bus_hold <= 1'b0;
    wait_idle();
    send_cmd(dbg_pkg::DBG_NOP, 16'd0, 32'd0);
    report_test("back-pressure");

    // Select attempt while busy
    bus_hold <= 1'b1;
    send_cmd(dbg_pkg::DBG_WRITE, 16'h0050, 32'hCAFE0001);
    select_module(dbg_pkg::CPU_MODULE_ID);
    send_cmd(dbg_pkg::DBG_NOP, 16'd0, 32'd0);
    bus_hold <= 1'b0;
    wait_idle();
    send_cmd(dbg_pkg::DBG_NOP, 16'd0, 32'd0);
    report_test("inhibit");

    // Stall write, breakpoint auto-stall, stall clear
    select_module(dbg_pkg::CPU_MODULE_ID);
    send_cmd(dbg_pkg::DBG_STALL, 16'd0, 32'd1);
    send_cmd(dbg_pkg::DBG_NOP, 16'd0, 32'd0);
    @(posedge tck);
    cpu_bp <= NUM_CPUS'(2);
    send_cmd(dbg_pkg::DBG_NOP, 16'd0, 32'd0);
    send_cmd(dbg_pkg::DBG_STALL, 16'd0, 32'd0);
    send_cmd(dbg_pkg::DBG_NOP, 16'd0, 32'd0);
    cpu_bp <= '0;
    select_module(dbg_pkg::BUS_MODULE_ID);
    report_test("cpu control");

    @(negedge tck);
    $display("tests %0d, checks %0d, errors %0d", test_num, check_cnt, error_cnt);
    if (rsp_count != accepted_cnt) begin
      $display("bus responses %0d do not match accepted commands %0d",
               rsp_count, accepted_cnt);
    end
    if (error_cnt == 0 && rsp_count == accepted_cnt) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/dbg_bus_master.sv
////////////////////
// Bus master
// Pops one command, drives the request, waits for the response
////////////////////
`timescale 1ns/1ps
`default_nettype none

module dbg_bus_master (
  input  wire logic                  tck_i,
  input  wire logic                  tlr_i,
  // From command FIFO
  input  wire logic                  cmd_valid_i,
  input  wire dbg_pkg::dbg_cmd_t     cmd_i,
  output logic                       cmd_ready_o,
  // Bus request
  output logic                       bus_req_valid_o,
  output dbg_pkg::dbg_bus_req_t      bus_req_o,
  input  wire logic                  bus_req_ready_i,
  // Bus response
  input  wire logic                  bus_rsp_valid_i,
  input  wire dbg_pkg::dbg_bus_rsp_t bus_rsp_i,
  // To bus unit
  output logic                       rsp_valid_o,
  output dbg_pkg::dbg_bus_rsp_t      rsp_o
);

  logic wait_q;
  logic idle;
  logic pop;
  logic rsp_done;

  // Idle means neither requesting nor waiting
  assign idle        = ~bus_req_valid_o & ~wait_q;
  assign cmd_ready_o = idle;
  assign pop         = cmd_valid_i & idle;

  // Responses only count once the request went out
  assign rsp_done = wait_q & bus_rsp_valid_i;

  ////////////////////
  // Phase control
  ////////////////////

  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      bus_req_valid_o <= 1'b0;
      wait_q          <= 1'b0;
      rsp_valid_o     <= 1'b0;
    end else begin
      rsp_valid_o <= rsp_done;
      if (pop) begin
        bus_req_valid_o <= 1'b1;
      end else if (bus_req_valid_o && bus_req_ready_i) begin
        bus_req_valid_o <= 1'b0;
        wait_q          <= 1'b1;
      end else if (rsp_done) begin
        wait_q <= 1'b0;
      end
    end
  end

  // Request payload, loaded at pop
  always_ff @(posedge tck_i) begin
    if (pop) begin
      bus_req_o.we    <= (cmd_i.op == dbg_pkg::DBG_WRITE);
      bus_req_o.addr  <= cmd_i.addr;
      bus_req_o.wdata <= cmd_i.data;
    end
  end

  // Response to the bus unit
  // rdata only moves on reads, so it always holds the last read value
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      rsp_o <= '0;
    end else if (rsp_done) begin
      rsp_o.err <= bus_rsp_i.err;
      if (!bus_req_o.we) begin
        rsp_o.rdata <= bus_rsp_i.rdata;
      end
    end
  end

  // Request held steady under back-pressure
  a_req_stable : assert property (@(posedge tck_i) disable iff (tlr_i)
    bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o && $stable(bus_req_o));

endmodule

`default_nettype wire

//--- src/dbg_bus_unit.sv
////////////////////
// Bus debug unit
// Command decode at Update-DR, FIFO push, pending count
// Sticky flags and status word shift-out
////////////////////
`timescale 1ns/1ps
`default_nettype none

module dbg_bus_unit #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic                  tck_i,
  input  wire logic                  tlr_i,
  input  wire logic                  shift_dr_i,
  input  wire logic                  capture_dr_i,
  input  wire logic                  update_dr_i,
  input  wire logic                  select_i,
  // Select bit and command slice of the main chain
  input  wire logic                  sel_bit_i,
  input  wire dbg_pkg::dbg_cmd_t     cmd_i,
  output logic                       tdo_o,
  output logic                       inhibit_o,
  // To command FIFO
  output logic                       cmd_valid_o,
  output dbg_pkg::dbg_cmd_t          cmd_o,
  input  wire logic                  cmd_ready_i,
  // From bus master
  input  wire logic                  rsp_valid_i,
  input  wire dbg_pkg::dbg_bus_rsp_t rsp_i
);

  // FIFO contents plus one in the master, plus headroom
  localparam int PEND_W = $clog2(FIFO_DEPTH + 2);

  logic                           do_update;
  logic                           is_bus_op;
  logic                           push;
  logic                           drop;
  logic                           capture;
  logic [PEND_W-1:0]              pending;
  logic                           err_q;
  logic                           ovf_q;
  logic [dbg_pkg::DATA_W-1:0]     last_rdata;
  logic [dbg_pkg::STATUS_LEN-1:0] status_sr;

  ////////////////////
  // Command decode
  ////////////////////

  // Select commands carry a module id, not a bus command
  assign do_update = update_dr_i & select_i & ~sel_bit_i;
  assign is_bus_op = (cmd_i.op == dbg_pkg::DBG_WRITE) | (cmd_i.op == dbg_pkg::DBG_READ);

  // Offered for one edge only
  assign cmd_valid_o = do_update & is_bus_op;
  assign cmd_o       = cmd_i;

  // Accepted or lost
  assign push = cmd_valid_o & cmd_ready_i;
  assign drop = cmd_valid_o & ~cmd_ready_i;

  ////////////////////
  // Pending work
  ////////////////////

  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      pending <= '0;
    end else if (push && !rsp_valid_i) begin
      pending <= pending + PEND_W'(1);
    end else if (!push && rsp_valid_i) begin
      pending <= pending - PEND_W'(1);
    end
  end

  // Busy doubles as the select inhibit
  assign inhibit_o = |pending;

  ////////////////////
  // Status
  ////////////////////

  assign capture = capture_dr_i & select_i;

  // Sticky until read out; a new event on the capture edge survives
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      err_q <= 1'b0;
      ovf_q <= 1'b0;
    end else begin
      err_q <= (err_q & ~capture) | (rsp_valid_i & rsp_i.err);
      ovf_q <= (ovf_q & ~capture) | drop;
    end
  end

  // Master keeps rdata unchanged across writes
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      last_rdata <= '0;
    end else if (rsp_valid_i) begin
      last_rdata <= rsp_i.rdata;
    end
  end

  // Busy, overflow, error, read data; LSB goes out first
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      status_sr <= '0;
    end else if (capture) begin
      status_sr <= {inhibit_o, ovf_q, err_q, last_rdata};
    end else if (shift_dr_i && select_i) begin
      status_sr <= {1'b0, status_sr[dbg_pkg::STATUS_LEN-1:1]};
    end
  end

  assign tdo_o = status_sr[0];

  // Every response matches an earlier push
  a_pending_no_underflow : assert property (@(posedge tck_i) disable iff (tlr_i)
    rsp_valid_i |-> (pending != '0));

endmodule

`default_nettype wire

//--- src/dbg_cmd_fifo.sv
////////////////////
// Command FIFO
// Circular buffer of bus commands, valid/ready both sides
////////////////////
`timescale 1ns/1ps
`default_nettype none

module dbg_cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic              tck_i,
  input  wire logic              tlr_i,
  // Input side
  input  wire logic              in_valid_i,
  input  wire dbg_pkg::dbg_cmd_t in_i,
  output logic                   in_ready_o,
  // Output side
  output logic                   out_valid_o,
  output dbg_pkg::dbg_cmd_t      out_o,
  input  wire logic              out_ready_i
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  dbg_pkg::dbg_cmd_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              full;
  logic              push;
  logic              pop;

  // Wrap at the depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign full        = (count == CNT_W'(FIFO_DEPTH));
  assign in_ready_o  = ~full;
  assign out_valid_o = (count != '0);
  assign out_o       = mem[rd_ptr];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // Storage
  always_ff @(posedge tck_i) begin
    if (push) begin
      mem[wr_ptr] <= in_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + CNT_W'(1);
      end else if (pop && !push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

  // Full buffer means the write pointer has come round to the read pointer
  a_no_push_full : assert property (@(posedge tck_i) disable iff (tlr_i)
    full |-> (wr_ptr == rd_ptr));

endmodule

`default_nettype wire

//--- src/dbg_cpu_unit.sv
////////////////////
// CPU run-control unit
// Stall register, breakpoint auto-stall, status shift-out
////////////////////
`timescale 1ns/1ps
`default_nettype none

module dbg_cpu_unit #(
  parameter int NUM_CPUS = 2
) (
  input  wire logic                tck_i,
  input  wire logic                tlr_i,
  input  wire logic                shift_dr_i,
  input  wire logic                capture_dr_i,
  input  wire logic                update_dr_i,
  input  wire logic                select_i,
  // Select bit and command slice of the main chain
  input  wire logic                sel_bit_i,
  input  wire dbg_pkg::dbg_cmd_t   cmd_i,
  output logic                     tdo_o,
  // CPU run control
  input  wire logic [NUM_CPUS-1:0] cpu_bp_i,
  output logic      [NUM_CPUS-1:0] cpu_stall_o
);

  logic                  stall_wr;
  logic [NUM_CPUS-1:0]   bp_q;
  logic [NUM_CPUS-1:0]   bp_rise;
  logic [NUM_CPUS-1:0]   stall_q;
  logic [2*NUM_CPUS-1:0] cap_sr;

  // Stall write, select commands ignored
  assign stall_wr = update_dr_i & select_i & ~sel_bit_i & (cmd_i.op == dbg_pkg::DBG_STALL);

  // Breakpoint edge detect
  assign bp_rise = cpu_bp_i & ~bp_q;

  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      bp_q <= '0;
    end else begin
      bp_q <= cpu_bp_i;
    end
  end

  // New breakpoint wins over a written clear
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      stall_q <= '0;
    end else if (stall_wr) begin
      stall_q <= cmd_i.data[NUM_CPUS-1:0] | bp_rise;
    end else begin
      stall_q <= stall_q | bp_rise;
    end
  end

  assign cpu_stall_o = stall_q;

  ////////////////////
  // Capture and shift
  ////////////////////

  // Breakpoints high half, stalls low half
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      cap_sr <= '0;
    end else if (capture_dr_i && select_i) begin
      cap_sr <= {bp_q, stall_q};
    end else if (shift_dr_i && select_i) begin
      cap_sr <= {1'b0, cap_sr[2*NUM_CPUS-1:1]};
    end
  end

  assign tdo_o = cap_sr[0];

endmodule

`default_nettype wire

//--- src/dbg_pkg.sv
////////////////////
// Debug subsystem shared definitions
// Field widths, chain lengths and module ids
// Opcode enum, command and bus structs
////////////////////
`default_nettype none

package dbg_pkg;

  ////////////////////
  // Field widths
  ////////////////////

  // Bus address and data
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // Module id field, right below the select bit
  localparam int MODULE_ID_W = 2;

  // Opcode field of a command
  localparam int OP_W = 2;

  // Select bit, opcode, address, data
  localparam int DATAREG_LEN = 1 + OP_W + ADDR_W + DATA_W;

  // Read data plus error, overflow and busy flags
  localparam int STATUS_LEN = DATA_W + 3;

  // Module ids on the debug chain
  // Ids 2 and 3 are reserved
  localparam logic [MODULE_ID_W-1:0] BUS_MODULE_ID = 2'd0;
  localparam logic [MODULE_ID_W-1:0] CPU_MODULE_ID = 2'd1;

  ////////////////////
  // Types
  ////////////////////

  // Command opcodes, STALL only meaningful to the CPU unit
  typedef enum logic [OP_W-1:0] {
    DBG_NOP   = 2'd0,
    DBG_WRITE = 2'd1,
    DBG_READ  = 2'd2,
    DBG_STALL = 2'd3
  } dbg_op_e;

  // Lower part of the main chain when the select bit is clear
  typedef struct packed {
    dbg_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } dbg_cmd_t;

  // Bus request payload
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } dbg_bus_req_t;

  // Bus response payload
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } dbg_bus_rsp_t;

endpackage

`default_nettype wire

//--- src/dbg_top.sv
////////////////////
// Debug chain top level
// Main input shift register, module select with inhibit
// TDO mux, bus and CPU debug units
////////////////////
`timescale 1ns/1ps
`default_nettype none

module dbg_top #(
  parameter int FIFO_DEPTH = 4,
  parameter int NUM_CPUS   = 2
) (
  input  wire logic                  tck_i,
  input  wire logic                  tlr_i,
  input  wire logic                  tdi_i,
  input  wire logic                  shift_dr_i,
  input  wire logic                  capture_dr_i,
  input  wire logic                  update_dr_i,
  input  wire logic                  debug_select_i,
  output logic                       tdo_o,
  // Bus request
  output logic                       bus_req_valid_o,
  output dbg_pkg::dbg_bus_req_t      bus_req_o,
  input  wire logic                  bus_req_ready_i,
  // Bus response
  input  wire logic                  bus_rsp_valid_i,
  input  wire dbg_pkg::dbg_bus_rsp_t bus_rsp_i,
  // CPU run control
  input  wire logic [NUM_CPUS-1:0]   cpu_bp_i,
  output logic      [NUM_CPUS-1:0]   cpu_stall_o
);

  localparam int NUM_MODULES = 2 ** dbg_pkg::MODULE_ID_W;

  // Main chain
  logic [dbg_pkg::DATAREG_LEN-1:0] input_sreg;
  logic                            sel_bit;
  logic [dbg_pkg::MODULE_ID_W-1:0] module_id_in;
  dbg_pkg::dbg_cmd_t               cmd;

  // Module selection
  logic [dbg_pkg::MODULE_ID_W-1:0] module_id;
  logic [NUM_MODULES-1:0]          module_sel;
  logic [NUM_MODULES-1:0]          module_inhibit;
  logic                            select_inhibit;
  logic                            bus_sel;
  logic                            cpu_sel;

  // Unit outputs
  logic                            tdo_bus;
  logic                            tdo_cpu;
  logic                            bus_inhibit;

  // Bus path links
  logic                            fifo_in_valid;
  logic                            fifo_in_ready;
  dbg_pkg::dbg_cmd_t               fifo_in;
  logic                            fifo_out_valid;
  logic                            fifo_out_ready;
  dbg_pkg::dbg_cmd_t               fifo_out;
  logic                            rsp_valid;
  dbg_pkg::dbg_bus_rsp_t           rsp;

  ////////////////////
  // Main shift register
  ////////////////////

  // MSB is the select bit, then module id or command
  assign sel_bit      = input_sreg[dbg_pkg::DATAREG_LEN-1];
  assign module_id_in = input_sreg[dbg_pkg::DATAREG_LEN-2 -: dbg_pkg::MODULE_ID_W];
  assign cmd          = input_sreg[dbg_pkg::DATAREG_LEN-2:0];

  // TDI enters at the MSB, shifting right
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      input_sreg <= '0;
    end else if (shift_dr_i && debug_select_i) begin
      input_sreg <= {tdi_i, input_sreg[dbg_pkg::DATAREG_LEN-1:1]};
    end
  end

  ////////////////////
  // Module select
  ////////////////////

  // Only the bus unit can hold off a new selection
  always_comb begin
    module_inhibit                         = '0;
    module_inhibit[dbg_pkg::BUS_MODULE_ID] = bus_inhibit;
  end

  assign select_inhibit = |module_inhibit;

  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      module_id <= dbg_pkg::BUS_MODULE_ID;
    end else if (update_dr_i && debug_select_i && sel_bit && !select_inhibit) begin
      module_id <= module_id_in;
    end
  end

  // One-hot decode of the current id
  always_comb begin
    module_sel            = '0;
    module_sel[module_id] = 1'b1;
  end

  // Units only see TAP states while the debug instruction is active
  assign bus_sel = module_sel[dbg_pkg::BUS_MODULE_ID] & debug_select_i;
  assign cpu_sel = module_sel[dbg_pkg::CPU_MODULE_ID] & debug_select_i;

  // TDO mux, reserved ids give 0
  always_comb begin
    case (module_id)
      dbg_pkg::BUS_MODULE_ID: tdo_o = tdo_bus;
      dbg_pkg::CPU_MODULE_ID: tdo_o = tdo_cpu;
      default:                tdo_o = 1'b0;
    endcase
  end

  ////////////////////
  // Debug units
  ////////////////////

  dbg_bus_unit #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_bus_unit (
    .tck_i       (tck_i),
    .tlr_i       (tlr_i),
    .shift_dr_i  (shift_dr_i),
    .capture_dr_i(capture_dr_i),
    .update_dr_i (update_dr_i),
    .select_i    (bus_sel),
    .sel_bit_i   (sel_bit),
    .cmd_i       (cmd),
    .tdo_o       (tdo_bus),
    .inhibit_o   (bus_inhibit),
    .cmd_valid_o (fifo_in_valid),
    .cmd_o       (fifo_in),
    .cmd_ready_i (fifo_in_ready),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp)
  );

  dbg_cmd_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_cmd_fifo (
    .tck_i      (tck_i),
    .tlr_i      (tlr_i),
    .in_valid_i (fifo_in_valid),
    .in_i       (fifo_in),
    .in_ready_o (fifo_in_ready),
    .out_valid_o(fifo_out_valid),
    .out_o      (fifo_out),
    .out_ready_i(fifo_out_ready)
  );

  dbg_bus_master u_bus_master (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .cmd_valid_i    (fifo_out_valid),
    .cmd_i          (fifo_out),
    .cmd_ready_o    (fifo_out_ready),
    .bus_req_valid_o(bus_req_valid_o),
    .bus_req_o      (bus_req_o),
    .bus_req_ready_i(bus_req_ready_i),
    .bus_rsp_valid_i(bus_rsp_valid_i),
    .bus_rsp_i      (bus_rsp_i),
    .rsp_valid_o    (rsp_valid),
    .rsp_o          (rsp)
  );

  dbg_cpu_unit #(
    .NUM_CPUS(NUM_CPUS)
  ) u_cpu_unit (
    .tck_i       (tck_i),
    .tlr_i       (tlr_i),
    .shift_dr_i  (shift_dr_i),
    .capture_dr_i(capture_dr_i),
    .update_dr_i (update_dr_i),
    .select_i    (cpu_sel),
    .sel_bit_i   (sel_bit),
    .cmd_i       (cmd),
    .tdo_o       (tdo_cpu),
    .cpu_bp_i    (cpu_bp_i),
    .cpu_stall_o (cpu_stall_o)
  );

  // Selection frozen while bus work is outstanding
  a_id_held_inhibit : assert property (@(posedge tck_i) disable iff (tlr_i)
    $changed(module_id) |-> !$past(bus_inhibit));

endmodule

`default_nettype wire
